//--- build.f
verilog/switch_pkg.sv
verilog/cam_pkg.sv
verilog/cam_if.sv
verilog/port_receive_fifo.sv
verilog/mac_cam_table.sv
verilog/core_data_orchestrator.sv
verilog/switch_top.sv
testbench/switch_tb.sv

//--- testbench/switch_tb.sv
`timescale 1ns/1ns

module switch_tb;

localparam int NUMBER_OF_PORTS  = 4;
localparam int TIMEOUT_LIMIT    = 15;
localparam int FIFO_DEPTH       = 16;
localparam int CLOCK_PERIOD     = 8;
localparam int FRAME_COUNT      = 22;
localparam int POOL_SIZE        = 6;
localparam int SYMBOL_BITS      = switch_pkg::SYMBOL_WIDTH;

logic                                           clock;
logic                                           reset_n;
logic   [NUMBER_OF_PORTS-1:0]                   receive_valid;
logic   [NUMBER_OF_PORTS-1:0][SYMBOL_BITS-1:0]  receive_symbol;
logic   [NUMBER_OF_PORTS-1:0]                   receive_full;
logic   [SYMBOL_BITS-1:0]                       transmit_symbol;
logic   [NUMBER_OF_PORTS-1:0]                   transmit_valid;

integer                             seed = 32'h5893_e27e;
int                                 errors = 0;
int                                 tests_passed = 0;
int                                 frames_checked = 0;
bit     [47:0]                      pool [POOL_SIZE];
int                                 learned_port [bit [47:0]];

// Frame under test per port, strays first when there are any
logic   [SYMBOL_BITS-1:0]           frame_mem [NUMBER_OF_PORTS][40];
int                                 frame_len [NUMBER_OF_PORTS];
int                                 frame_start [NUMBER_OF_PORTS];
bit     [47:0]                      frame_src [NUMBER_OF_PORTS];
bit     [47:0]                      frame_dst [NUMBER_OF_PORTS];

// Collected transmit side
logic   [SYMBOL_BITS-1:0]           out_sym [$];
logic   [NUMBER_OF_PORTS-1:0]       out_mask [$];
time                                out_time [$];

switch_top #(
    .NUMBER_OF_PORTS    (NUMBER_OF_PORTS),
    .TIMEOUT_LIMIT      (16'(TIMEOUT_LIMIT)),
    .TABLE_DEPTH        (8),
    .FIFO_DEPTH         (FIFO_DEPTH)
) dut0 (
    .clock              (clock),
    .reset_n            (reset_n),
    .receive_valid      (receive_valid),
    .receive_symbol     (receive_symbol),
    .receive_full       (receive_full),
    .transmit_symbol    (transmit_symbol),
    .transmit_valid     (transmit_valid)
);

initial clock = 1'b0;
always #(CLOCK_PERIOD/2) clock = ~clock;

initial begin
    #(FRAME_COUNT * 200 * CLOCK_PERIOD);
    $display("Watchdog expired after %0d cycles with tests still running", FRAME_COUNT * 200);
    $display("Simulation failed");
    $finish;
end

always @(negedge clock) begin
    if (reset_n && transmit_valid != '0) begin
        out_sym.push_back(transmit_symbol);
        out_mask.push_back(transmit_valid);
        out_time.push_back($time);
    end
end

//////////////////////////////////////////////////////////////////////
// Reference model

function automatic int random_below(input int range);
    return ($random(seed) & 32'h7fff_ffff) % range;
endfunction

// Learn the sender, then known destination or flood
function automatic logic [NUMBER_OF_PORTS-1:0] learn_and_forward(
    input int port, input bit [47:0] src, input bit [47:0] dst);
    learned_port[src] = port;
    if (learned_port.exists(dst)) begin
        return NUMBER_OF_PORTS'(1) << learned_port[dst];
    end
    return ~(NUMBER_OF_PORTS'(1) << port);
endfunction

//////////////////////////////////////////////////////////////////////
// Stimulus

task automatic make_frame(input int port, input bit [47:0] src, input bit [47:0] dst,
                          input int strays);
    int n;
    int payload;
    n = 0;
    repeat (strays) begin
        frame_mem[port][n] = {1'b0, 8'($random(seed))};
        n++;
    end
    for (int b = 0; b < switch_pkg::MAC_BYTES; b++) begin
        frame_mem[port][n] = {b == 0, dst[47 - 8*b -: 8]};
        n++;
    end
    for (int b = 0; b < switch_pkg::MAC_BYTES; b++) begin
        frame_mem[port][n] = {1'b0, src[47 - 8*b -: 8]};
        n++;
    end
    payload = 1 + random_below(20);
    repeat (payload) begin
        frame_mem[port][n] = {1'b0, 8'($random(seed))};
        n++;
    end
    frame_len[port]     = n;
    frame_start[port]   = strays;
    frame_src[port]     = src;
    frame_dst[port]     = dst;
endtask

// Holds off while the FIFO is full
task automatic push_frame(input int port);
    for (int i = 0; i < frame_len[port]; i++) begin
        @(negedge clock);
        receive_valid[port] = 1'b0;
        // Buffer starts empty, so fewer pushes than entries cannot fill it
        assert (i >= FIFO_DEPTH || !receive_full[port]) else begin
            $display("Fail at %0t: receive_full[%0d] expected 0 got %b",
                     $time, port, receive_full[port]);
            errors++;
        end
        while (receive_full[port]) begin
            @(negedge clock);
        end
        receive_valid[port]     = 1'b1;
        receive_symbol[port]    = frame_mem[port][i];
    end
    @(negedge clock);
    receive_valid[port] = 1'b0;
endtask

task automatic wait_for_output(input int count, input int limit);
    int waited;
    waited = 0;
    while (out_sym.size() < count && waited < limit) begin
        @(negedge clock);
        waited++;
    end
endtask

task automatic flush_output();
    out_sym.delete();
    out_mask.delete();
    out_time.delete();
endtask

//////////////////////////////////////////////////////////////////////
// Checking

task automatic check_frame(input int port);
    logic   [NUMBER_OF_PORTS-1:0]   mask;
    logic   [NUMBER_OF_PORTS-1:0]   valid;
    logic   [SYMBOL_BITS-1:0]       expected;
    logic   [SYMBOL_BITS-1:0]       symbol;
    time                            stamp;
    int                             count;
    mask    = learn_and_forward(port, frame_src[port], frame_dst[port]);
    count   = frame_len[port] - frame_start[port];
    frames_checked++;
    assert (out_sym.size() >= count) else begin
        $display("Frame from port %0d came out %0d symbols short",
                 port, count - out_sym.size());
        errors++;
    end
    for (int i = 0; i < count && out_sym.size() > 0; i++) begin
        expected    = frame_mem[port][frame_start[port] + i];
        symbol      = out_sym.pop_front();
        valid       = out_mask.pop_front();
        stamp       = out_time.pop_front();
        assert (symbol == expected) else begin
            $display("Fail at %0t: transmit_symbol expected %h got %h", stamp, expected, symbol);
            errors++;
        end
        assert (valid == mask) else begin
            $display("Fail at %0t: transmit_valid expected %b got %b", stamp, mask, valid);
            errors++;
        end
    end
endtask

task automatic check_nothing_left(input string after);
    assert (out_sym.size() == 0) else begin
        $display("Unexpected output of %0d symbols after %s", out_sym.size(), after);
        errors++;
        flush_output();
    end
endtask

task automatic run_frame(input int port, input bit [47:0] src, input bit [47:0] dst,
                         input int strays);
    make_frame(port, src, dst, strays);
    push_frame(port);
    wait_for_output(frame_len[port] - strays, 200);
    repeat (TIMEOUT_LIMIT + 10) @(negedge clock);
    check_frame(port);
    check_nothing_left("a single frame");
endtask

// One frame per port at once, expected back whole in port order
task automatic run_batch();
    int         total;
    int         prev;
    int         served;
    bit [47:0]  seen;
    total = 0;
    for (int p = 0; p < NUMBER_OF_PORTS; p++) begin
        make_frame(p, pool[p], pool[(p + 1 + random_below(POOL_SIZE - 1)) % POOL_SIZE], 0);
        total += frame_len[p];
    end
    for (int p = 0; p < NUMBER_OF_PORTS; p++) begin
        fork
            automatic int q = p;
            push_frame(q);
        join_none
    end
    wait fork;
    wait_for_output(total, 800);
    repeat (TIMEOUT_LIMIT + 10) @(negedge clock);
    prev = -1;
    for (int k = 0; k < NUMBER_OF_PORTS; k++) begin
        served  = -1;
        seen    = '0;
        if (out_sym.size() >= 12) begin
            for (int b = 0; b < switch_pkg::MAC_BYTES; b++) begin
                seen = {seen[39:0], out_sym[6 + b][7:0]};
            end
            for (int p = 0; p < NUMBER_OF_PORTS; p++) begin
                if (frame_src[p] == seen) begin
                    served = p;
                end
            end
        end
        assert (served >= 0) else begin
            $display("Frame %0d of the batch is missing or has an unknown source", k);
            errors++;
        end
        if (served < 0) begin
            break;
        end
        if (prev >= 0) begin
            assert (served == (prev + 1) % NUMBER_OF_PORTS) else begin
                $display("Fail at %0t: served port expected %0d got %0d",
                         out_time[0], (prev + 1) % NUMBER_OF_PORTS, served);
                errors++;
            end
        end
        check_frame(served);
        prev = served;
    end
    check_nothing_left("the batch");
endtask

task automatic report_test(input int number, input string name, input int errors_before);
    if (errors == errors_before) begin
        tests_passed++;
        $display("Test %0d %s: passed", number, name);
    end
    else begin
        $display("Test %0d %s: FAILED with %0d errors", number, name, errors - errors_before);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Test sequence

initial begin
    int start_errors;
    int a;
    int b;
    reset_n         = 1'b0;
    receive_valid   = '0;
    receive_symbol  = '0;
    // Low byte keeps the pool distinct
    for (int i = 0; i < POOL_SIZE; i++) begin
        pool[i] = {16'($random(seed)), 24'($random(seed)), 8'(i)};
    end
    repeat (4) @(negedge clock);
    reset_n = 1'b1;
    repeat (2) @(negedge clock);

    start_errors = errors;
    for (int k = 0; k < 3; k++) begin
        run_frame(random_below(NUMBER_OF_PORTS), pool[k], pool[5], 0);
    end
    report_test(1, "unknown destination floods", start_errors);

    start_errors = errors;
    for (int k = 0; k < 3; k++) begin
        run_frame(random_below(NUMBER_OF_PORTS), pool[3], pool[k], 0);
    end
    report_test(2, "known destination goes to one port", start_errors);

    start_errors = errors;
    for (int k = 0; k < 8; k++) begin
        a = random_below(POOL_SIZE);
        b = (a + 1 + random_below(POOL_SIZE - 1)) % POOL_SIZE;
        run_frame(random_below(NUMBER_OF_PORTS), pool[a], pool[b], 0);
    end
    report_test(3, "frame contents are exact", start_errors);

    start_errors = errors;
    a = random_below(NUMBER_OF_PORTS);
    b = (a + 1 + random_below(NUMBER_OF_PORTS - 1)) % NUMBER_OF_PORTS;
    run_frame(a, pool[4], pool[0], 0);
    run_frame(b, pool[4], pool[1], 0);
    run_frame((b + 1) % NUMBER_OF_PORTS, pool[2], pool[4], 0);
    report_test(4, "moved station is relearned", start_errors);

    start_errors = errors;
    a = random_below(POOL_SIZE);
    run_frame(random_below(NUMBER_OF_PORTS), pool[a], pool[(a + 1) % POOL_SIZE],
              1 + random_below(4));
    report_test(5, "stray symbols are dropped", start_errors);

    start_errors = errors;
    run_batch();
    report_test(6, "receive ports served in turn", start_errors);

    $display("Tests passed %0d of 6, frames checked %0d, errors %0d",
             tests_passed, frames_checked, errors);
    if (errors == 0) begin
        $display("Simulation completed successfully");
    end
    else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

//--- verilog/switch_top.sv
`timescale 1ns/1ns

module switch_top #(
    parameter int           NUMBER_OF_PORTS = 4,
    parameter logic [15:0]  TIMEOUT_LIMIT   = 16'd15,
    parameter int           TABLE_DEPTH     = 8,
    parameter int           FIFO_DEPTH      = 16
)(
    input   wire                                                    clock,
    input   wire                                                    reset_n,
    input   wire    [NUMBER_OF_PORTS-1:0]                           receive_valid,
    input   wire    [NUMBER_OF_PORTS-1:0][switch_pkg::SYMBOL_WIDTH-1:0] receive_symbol,
    output  logic   [NUMBER_OF_PORTS-1:0]                           receive_full,
    output  logic   [switch_pkg::SYMBOL_WIDTH-1:0]                  transmit_symbol,
    output  logic   [NUMBER_OF_PORTS-1:0]                           transmit_valid
);

logic   [NUMBER_OF_PORTS-1:0]                           receive_data_enable;
logic   [NUMBER_OF_PORTS-1:0][switch_pkg::SYMBOL_WIDTH-1:0] receive_data;
logic   [NUMBER_OF_PORTS-1:0]                           receive_data_ready;

cam_if #(.NUMBER_OF_PORTS(NUMBER_OF_PORTS)) cam0 ();

// One receive buffer per port
for (genvar p = 0; p < NUMBER_OF_PORTS; p++) begin : g_port
    port_receive_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) receive_fifo (
        .clock          (clock),
        .reset_n        (reset_n),
        .push           (receive_valid[p]),
        .push_symbol    (receive_symbol[p]),
        .pop            (receive_data_ready[p]),
        .full           (receive_full[p]),
        .not_empty      (receive_data_enable[p]),
        .head_symbol    (receive_data[p])
    );
end

core_data_orchestrator #(
    .NUMBER_OF_PORTS    (NUMBER_OF_PORTS),
    .TIMEOUT_LIMIT      (TIMEOUT_LIMIT)
) orchestrator0 (
    .clock                      (clock),
    .reset_n                    (reset_n),
    .port_receive_data_enable   (receive_data_enable),
    .port_receive_data          (receive_data),
    .port_receive_data_ready    (receive_data_ready),
    .cam                        (cam0.orchestrator),
    .port_transmit_data         (transmit_symbol),
    .port_transmit_data_valid   (transmit_valid)
);

mac_cam_table #(
    .NUMBER_OF_PORTS    (NUMBER_OF_PORTS),
    .TABLE_DEPTH        (TABLE_DEPTH)
) cam_table0 (
    .clock      (clock),
    .reset_n    (reset_n),
    .cam        (cam0.cam_table)
);

endmodule

//--- verilog/core_data_orchestrator.sv
`timescale 1ns/1ns

module core_data_orchestrator #(
    parameter int           NUMBER_OF_PORTS = 4,
    parameter logic [15:0]  TIMEOUT_LIMIT   = 16'd15
)(
    input   wire                                                    clock,
    input   wire                                                    reset_n,
    input   wire    [NUMBER_OF_PORTS-1:0]                           port_receive_data_enable,
    input   wire    [NUMBER_OF_PORTS-1:0][switch_pkg::SYMBOL_WIDTH-1:0] port_receive_data,
    output  logic   [NUMBER_OF_PORTS-1:0]                           port_receive_data_ready,
    cam_if.orchestrator                                             cam,
    output  logic   [switch_pkg::SYMBOL_WIDTH-1:0]                  port_transmit_data,
    output  logic   [NUMBER_OF_PORTS-1:0]                           port_transmit_data_valid
);

localparam int PORT_BITS    = $clog2(NUMBER_OF_PORTS);
localparam int BYTE_TOP     = switch_pkg::START_BIT - 1;
localparam int MAC_TOP      = switch_pkg::MAC_WIDTH - 1;

localparam logic [3:0] S_FIND_START_BIT             = 4'd0;
localparam logic [3:0] S_GET_MAC_DESTINATION        = 4'd1;
localparam logic [3:0] S_GET_MAC_SOURCE             = 4'd2;
localparam logic [3:0] S_LOOKUP_SOURCE_PORT         = 4'd3;
localparam logic [3:0] S_DELETE_OLD_TABLE_ENTRY     = 4'd4;
localparam logic [3:0] S_UPDATE_TABLE               = 4'd5;
localparam logic [3:0] S_LOOKUP_DESTINATION_PORT    = 4'd6;
localparam logic [3:0] S_TRANSMIT_MAC_DESTINATION   = 4'd7;
localparam logic [3:0] S_TRANSMIT_MAC_SOURCE        = 4'd8;
localparam logic [3:0] S_TRANSMIT_DATA              = 4'd9;

logic   [3:0]                           state, _state;
logic   [PORT_BITS-1:0]                 port_select, _port_select;
logic   [PORT_BITS-1:0]                 next_port;
logic   [2:0]                           process_counter, _process_counter;
logic   [15:0]                          timeout_count, _timeout_count;
logic   [MAC_TOP:0]                     mac_destination, _mac_destination;
logic   [MAC_TOP:0]                     mac_source, _mac_source;
logic   [NUMBER_OF_PORTS-1:0]           target_transmit_port, _target_transmit_port;
logic   [switch_pkg::SYMBOL_WIDTH-1:0]  _port_transmit_data;
logic   [NUMBER_OF_PORTS-1:0]           _port_transmit_data_valid;
logic   [switch_pkg::SYMBOL_WIDTH-1:0]  head;
logic                                   head_valid;

assign head         = port_receive_data[port_select];
assign head_valid   = port_receive_data_enable[port_select];
assign next_port    = (port_select == PORT_BITS'(NUMBER_OF_PORTS-1)) ? '0 : port_select + 1'b1;

always_comb begin
    _state                      = state;
    _port_select                = port_select;
    _process_counter            = process_counter;
    _timeout_count              = timeout_count;
    _mac_destination            = mac_destination;
    _mac_source                 = mac_source;
    _target_transmit_port       = target_transmit_port;
    _port_transmit_data         = port_transmit_data;
    _port_transmit_data_valid   = '0;
    port_receive_data_ready     = '0;
    cam.match_valid             = 1'b0;
    cam.write_valid             = 1'b0;
    cam.delete_key              = 1'b0;
    cam.key                     = mac_source;
    cam.index                   = port_select;

    case (state)
        ////////////////////////////////////////////////////////////////////
        // Header collection
        S_FIND_START_BIT: begin
            if (head_valid) begin
                // Stray symbols are popped and thrown away
                port_receive_data_ready[port_select] = 1'b1;
                if (head[switch_pkg::START_BIT]) begin
                    _mac_destination    = {mac_destination[MAC_TOP-8:0], head[BYTE_TOP:0]};
                    _process_counter    = 3'(switch_pkg::MAC_BYTES - 2);
                    _state              = S_GET_MAC_DESTINATION;
                end
            end
            else begin
                _port_select = next_port;
            end
        end
        S_GET_MAC_DESTINATION: begin
            if (head_valid) begin
                port_receive_data_ready[port_select] = 1'b1;
                _mac_destination    = {mac_destination[MAC_TOP-8:0], head[BYTE_TOP:0]};
                _process_counter    = process_counter - 1'b1;
                if (process_counter == '0) begin
                    _process_counter    = 3'(switch_pkg::MAC_BYTES - 1);
                    _state              = S_GET_MAC_SOURCE;
                end
            end
        end
        S_GET_MAC_SOURCE: begin
            if (head_valid) begin
                port_receive_data_ready[port_select] = 1'b1;
                _mac_source         = {mac_source[MAC_TOP-8:0], head[BYTE_TOP:0]};
                _process_counter    = process_counter - 1'b1;
                if (process_counter == '0) begin
                    _process_counter    = '0;
                    _state              = S_LOOKUP_SOURCE_PORT;
                end
            end
        end
        ////////////////////////////////////////////////////////////////////
        // Learning
        S_LOOKUP_SOURCE_PORT: begin
            if (process_counter == '0) begin
                cam.match_valid     = 1'b1;
                _process_counter    = 3'd1;
            end
            else if (cam.no_match) begin
                _process_counter    = '0;
                _state              = S_UPDATE_TABLE;
            end
            else if (cam.match_enable) begin
                _process_counter    = '0;
                // Station moved: drop the stale entry first
                _state = (cam.match_index == port_select) ? S_LOOKUP_DESTINATION_PORT
                                                          : S_DELETE_OLD_TABLE_ENTRY;
            end
        end
        S_DELETE_OLD_TABLE_ENTRY: begin
            cam.delete_key  = 1'b1;
            _state          = S_UPDATE_TABLE;
        end
        S_UPDATE_TABLE: begin
            cam.write_valid = 1'b1;
            _state          = S_LOOKUP_DESTINATION_PORT;
        end
        S_LOOKUP_DESTINATION_PORT: begin
            cam.key = mac_destination;
            if (process_counter == '0) begin
                cam.match_valid     = 1'b1;
                _process_counter    = 3'd1;
            end
            else if (cam.no_match || cam.match_enable) begin
                if (cam.match_enable) begin
                    _target_transmit_port                   = '0;
                    _target_transmit_port[cam.match_index]  = 1'b1;
                end
                else begin
                    // Flood, but never back to the sender
                    _target_transmit_port                   = '1;
                    _target_transmit_port[port_select]      = 1'b0;
                end
                _port_transmit_data         = {1'b1, mac_destination[MAC_TOP -: 8]};
                _port_transmit_data_valid   = _target_transmit_port;
                _mac_destination            = {mac_destination[MAC_TOP-8:0], 8'h00};
                _process_counter            = 3'(switch_pkg::MAC_BYTES - 2);
                _state                      = S_TRANSMIT_MAC_DESTINATION;
            end
        end
        ////////////////////////////////////////////////////////////////////
        // Forwarding
        S_TRANSMIT_MAC_DESTINATION: begin
            _port_transmit_data         = {1'b0, mac_destination[MAC_TOP -: 8]};
            _port_transmit_data_valid   = target_transmit_port;
            _mac_destination            = {mac_destination[MAC_TOP-8:0], 8'h00};
            _process_counter            = process_counter - 1'b1;
            if (process_counter == '0) begin
                _process_counter    = 3'(switch_pkg::MAC_BYTES - 1);
                _state              = S_TRANSMIT_MAC_SOURCE;
            end
        end
        S_TRANSMIT_MAC_SOURCE: begin
            _port_transmit_data         = {1'b0, mac_source[MAC_TOP -: 8]};
            _port_transmit_data_valid   = target_transmit_port;
            _mac_source                 = {mac_source[MAC_TOP-8:0], 8'h00};
            _process_counter            = process_counter - 1'b1;
            if (process_counter == '0) begin
                _timeout_count  = TIMEOUT_LIMIT;
                _state          = S_TRANSMIT_DATA;
            end
        end
        S_TRANSMIT_DATA: begin
            if (head_valid && head[switch_pkg::START_BIT]) begin
                // Next frame stays queued for a later turn
                _port_select    = next_port;
                _state          = S_FIND_START_BIT;
            end
            else if (head_valid) begin
                port_receive_data_ready[port_select] = 1'b1;
                _port_transmit_data         = {1'b0, head[BYTE_TOP:0]};
                _port_transmit_data_valid   = target_transmit_port;
                _timeout_count              = TIMEOUT_LIMIT;
            end
            else if (timeout_count == '0) begin
                _port_select    = next_port;
                _state          = S_FIND_START_BIT;
            end
            else begin
                _timeout_count  = timeout_count - 1'b1;
            end
        end
        default: begin
            _state = S_FIND_START_BIT;
        end
    endcase
end

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        state                       <= S_FIND_START_BIT;
        port_select                 <= '0;
        process_counter             <= '0;
        timeout_count               <= '0;
        port_transmit_data_valid    <= '0;
    end
    else begin
        state                       <= _state;
        port_select                 <= _port_select;
        process_counter             <= _process_counter;
        timeout_count               <= _timeout_count;
        port_transmit_data_valid    <= _port_transmit_data_valid;
    end
end

always_ff @(posedge clock) begin
    mac_destination         <= _mac_destination;
    mac_source              <= _mac_source;
    target_transmit_port    <= _target_transmit_port;
    port_transmit_data      <= _port_transmit_data;
end

endmodule

//--- verilog/mac_cam_table.sv
`timescale 1ns/1ns

module mac_cam_table #(
    parameter int NUMBER_OF_PORTS   = 4,
    parameter int TABLE_DEPTH       = 8
)(
    input   wire                clock,
    input   wire                reset_n,
    cam_if.cam_table            cam
);

localparam int PORT_BITS    = $clog2(NUMBER_OF_PORTS);
localparam int STORED_BITS  = cam_pkg::MAX_PORT_BITS;
localparam int ENTRY_BITS   = $clog2(TABLE_DEPTH);

logic   [TABLE_DEPTH-1:0]           entry_valid;
logic   [cam_pkg::KEY_WIDTH-1:0]    entry_key [TABLE_DEPTH];
logic   [STORED_BITS-1:0]           entry_port [TABLE_DEPTH];
logic   [TABLE_DEPTH-1:0]           key_equal;
logic                               hit;
logic   [STORED_BITS-1:0]           hit_port;
logic                               have_free;
logic   [ENTRY_BITS-1:0]            free_slot;
logic   [ENTRY_BITS-1:0]            victim;
logic   [ENTRY_BITS-1:0]            write_slot;

////////////////////////////////////////////////////////////////////////
// Parallel compare, lowest entry wins
always_comb begin
    hit         = 1'b0;
    hit_port    = '0;
    have_free   = 1'b0;
    free_slot   = '0;
    for (int i = TABLE_DEPTH-1; i >= 0; i--) begin
        key_equal[i] = entry_valid[i] && (entry_key[i] == cam.key);
        if (key_equal[i]) begin
            hit         = 1'b1;
            hit_port    = entry_port[i];
        end
        if (!entry_valid[i]) begin
            have_free   = 1'b1;
            free_slot   = ENTRY_BITS'(i);
        end
    end
    // Full table: overwrite in round-robin order
    write_slot = have_free ? free_slot : victim;
end

////////////////////////////////////////////////////////////////////////
always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        entry_valid         <= '0;
        victim              <= '0;
        cam.match_enable    <= 1'b0;
        cam.no_match        <= 1'b0;
    end
    else begin
        cam.match_enable    <= cam.match_valid && hit;
        cam.no_match        <= cam.match_valid && !hit;
        if (cam.delete_key) begin
            entry_valid     <= entry_valid & ~key_equal;
        end
        if (cam.write_valid) begin
            entry_valid[write_slot] <= 1'b1;
            if (!have_free) begin
                victim <= (victim == ENTRY_BITS'(TABLE_DEPTH-1)) ? '0 : victim + 1'b1;
            end
        end
    end
end

always_ff @(posedge clock) begin
    cam.match_index <= PORT_BITS'(hit_port);
    if (cam.write_valid) begin
        entry_key[write_slot]   <= cam.key;
        entry_port[write_slot]  <= STORED_BITS'(cam.index);
    end
end

endmodule

//--- verilog/port_receive_fifo.sv
`timescale 1ns/1ns

module port_receive_fifo #(
    parameter int FIFO_DEPTH = 16
)(
    input   wire                                    clock,
    input   wire                                    reset_n,
    input   wire                                    push,
    input   wire    [switch_pkg::SYMBOL_WIDTH-1:0]  push_symbol,
    input   wire                                    pop,
    output  logic                                   full,
    output  logic                                   not_empty,
    output  logic   [switch_pkg::SYMBOL_WIDTH-1:0]  head_symbol
);

localparam int POINTER_BITS = $clog2(FIFO_DEPTH);

logic   [switch_pkg::SYMBOL_WIDTH-1:0]  memory [FIFO_DEPTH];
logic   [POINTER_BITS-1:0]              read_pointer;
logic   [POINTER_BITS-1:0]              write_pointer;
logic   [POINTER_BITS:0]                count;
logic                                   do_push;
logic                                   do_pop;

assign full         = (count == (POINTER_BITS+1)'(FIFO_DEPTH));
assign not_empty    = (count != '0);
assign head_symbol  = memory[read_pointer];

// Pushes into a full buffer are lost
assign do_push      = push && !full;
assign do_pop       = pop && not_empty;

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        read_pointer    <= '0;
        write_pointer   <= '0;
        count           <= '0;
    end
    else begin
        if (do_push) begin
            write_pointer   <= write_pointer + 1'b1;
        end
        if (do_pop) begin
            read_pointer    <= read_pointer + 1'b1;
        end
        if (do_push && !do_pop) begin
            count           <= count + 1'b1;
        end
        else if (do_pop && !do_push) begin
            count           <= count - 1'b1;
        end
    end
end

always_ff @(posedge clock) begin
    if (do_push) begin
        memory[write_pointer]   <= push_symbol;
    end
end

endmodule

//--- verilog/cam_if.sv
`timescale 1ns/1ns

interface cam_if #(
    parameter int NUMBER_OF_PORTS = 4
);

    localparam int PORT_BITS = $clog2(NUMBER_OF_PORTS);

    // Requests from the orchestrator
    logic                               match_valid;
    logic   [cam_pkg::KEY_WIDTH-1:0]    key;
    logic                               write_valid;
    logic   [PORT_BITS-1:0]             index;
    logic                               delete_key;

    // Lookup answer
    logic                               match_enable;
    logic                               no_match;
    logic   [PORT_BITS-1:0]             match_index;

    modport orchestrator (
        output match_valid, key, write_valid, index, delete_key,
        input  match_enable, no_match, match_index
    );

    modport cam_table (
        input  match_valid, key, write_valid, index, delete_key,
        output match_enable, no_match, match_index
    );

endinterface

//--- verilog/cam_pkg.sv
package cam_pkg;

    // Table key is a full MAC address
    localparam int KEY_WIDTH     = 48;

    // Stored port index, room for up to 16 ports
    localparam int MAX_PORT_BITS = 4;

endpackage

//--- verilog/switch_pkg.sv
package switch_pkg;

    // One receive/transmit symbol: start flag above one data byte
    localparam int SYMBOL_WIDTH = 9;
    localparam int START_BIT    = 8;

    // Ethernet address layout
    localparam int MAC_BYTES    = 6;
    localparam int MAC_WIDTH    = 48;

endpackage
